//--- project.f
logic/irq_pkg.sv
logic/display_event_detect.sv
logic/irq_controller.sv
logic/irq_reg_port.sv
logic/irq_subsystem.sv
sim/irq_subsystem_tb.sv

//--- Bender.yml
package:
  name: irq_subsystem

sources:
  # Package first, then the blocks, then the top level
  - logic/irq_pkg.sv
  - logic/display_event_detect.sv
  - logic/irq_controller.sv
  - logic/irq_reg_port.sv
  - logic/irq_subsystem.sv

  - target: simulation
    files:
      - sim/irq_subsystem_tb.sv

//--- sim/irq_subsystem_tb.sv
// Self-checking testbench for the interrupt subsystem, run as top module irq_subsystem_tb
`timescale 1ns/1ps

module irq_subsystem_tb;

    localparam int unsigned timeout_cycles = 4000; // About 1500 cycles of tests plus margin
    localparam logic [4:0]  mode_user      = 5'b10000;

    logic                  clock;
    logic                  reset;
    irq_pkg::display_pos_t display_pos;
    irq_pkg::periph_irq_t  periph;
    logic [4:0]            cpu_mode;
    irq_pkg::reg_req_t     req;
    logic                  req_valid;
    logic                  rsp_ready;
    logic                  nirq;
    logic                  req_ready;
    logic [15:0]           rsp_data;
    logic                  rsp_valid;

    logic                  stall_mode;
    int unsigned           cycle_count = 0;
    logic [10:0]           periph_bits;
    logic [1:0]            sel_bits;

    // Reference model state
    logic [2:0]            m_cond;
    logic [2:0]            m_cond_prev;
    irq_pkg::irq_mask_t    m_set;
    irq_pkg::irq_mask_t    m_flags;
    irq_pkg::irq_mask_t    m_ie;
    irq_pkg::irq_mask_t    m_ack;
    logic                  m_ime;
    logic                  m_nirq;
    logic                  m_accept;
    logic                  m_rsp_valid;
    logic [15:0]           m_rsp_data;
    logic [15:0]           m_read;

    irq_subsystem irq_subsystem_i (
        .clock       (clock),
        .reset       (reset),
        .display_pos (display_pos),
        .periph      (periph),
        .cpu_mode    (cpu_mode),
        .req         (req),
        .req_valid   (req_valid),
        .rsp_ready   (rsp_ready),
        .nirq        (nirq),
        .req_ready   (req_ready),
        .rsp_data    (rsp_data),
        .rsp_valid   (rsp_valid)
    );

    always #2 clock = ~clock;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "testbench stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] expected);
        report_failure($sformatf("mismatch at %0t ns: %s got 0x%0h expected 0x%0h",
                                 $time, name, got, expected));
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            report_failure("run did not finish within the cycle limit");
        end
    end

    // Display conditions and source lines as flag bits
    always_comb begin
        m_cond[0] = (display_pos.hcount == 9'd240);
        m_cond[1] = (display_pos.vcount == 8'd160);
        m_cond[2] = (display_pos.vcount == display_pos.set_vcount);
        m_set = '0;
        m_set[2:0]   = m_cond & ~m_cond_prev;
        m_set[6:3]   = periph.timer;
        m_set[7]     = periph.serial;
        m_set[11:8]  = periph.dma;
        m_set[12]    = periph.keypad;
        m_set[13]    = periph.game_pak;
        m_accept = req_valid & ~m_rsp_valid;
        case (req.sel)
            irq_pkg::reg_ie:  m_read = {2'b00, m_ie};
            irq_pkg::reg_if:  m_read = {2'b00, m_ie & m_flags};
            irq_pkg::reg_ime: m_read = {15'd0, m_ime};
            default:          m_read = 16'd0;
        endcase
    end

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            m_cond_prev <= '0;
            m_flags     <= '0;
            m_ie        <= '0;
            m_ack       <= '0;
            m_ime       <= 1'b0;
            m_nirq      <= 1'b1;
            m_rsp_valid <= 1'b0;
            m_rsp_data  <= '0;
        end else begin
            m_cond_prev <= m_cond;
            m_flags     <= (m_flags | m_set) & ~m_ack; // Clear beats set
            m_nirq      <= ~((|(m_ie & m_flags)) & m_ime & (cpu_mode != 5'b10010));
            m_ack       <= '0;
            if (m_accept && req.write) begin
                case (req.sel)
                    irq_pkg::reg_ie:  m_ie  <= req.wdata[13:0];
                    irq_pkg::reg_if:  m_ack <= req.wdata[13:0];
                    irq_pkg::reg_ime: m_ime <= req.wdata[0];
                    default: ;
                endcase
            end
            if (m_accept) begin
                m_rsp_valid <= 1'b1;
                m_rsp_data  <= m_read;
            end else if (rsp_ready) begin
                m_rsp_valid <= 1'b0;
            end
        end
    end

    nirq_check: assert property (@(posedge clock) disable iff (reset) nirq == m_nirq)
        else report_mismatch("nirq", $sampled(nirq), $sampled(m_nirq));

    flags_check: assert property (@(posedge clock) disable iff (reset)
        irq_subsystem_i.irq_controller_i.flags == m_flags)
        else report_mismatch("flags", $sampled(irq_subsystem_i.irq_controller_i.flags),
                             $sampled(m_flags));

    rsp_valid_check: assert property (@(posedge clock) disable iff (reset)
        rsp_valid == m_rsp_valid)
        else report_mismatch("rsp_valid", $sampled(rsp_valid), $sampled(m_rsp_valid));

    req_ready_check: assert property (@(posedge clock) disable iff (reset)
        req_ready == !m_rsp_valid)
        else report_mismatch("req_ready", $sampled(req_ready), $sampled(!m_rsp_valid));

    rsp_data_check: assert property (@(posedge clock) disable iff (reset)
        rsp_valid |-> (rsp_data == m_rsp_data))
        else report_mismatch("rsp_data", $sampled(rsp_data), $sampled(m_rsp_data));

    stall_hold_check: assert property (@(posedge clock) disable iff (reset)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data)))
        else report_failure("response changed or vanished while the CPU stalled it");

    // Response stalls only in the random phase
    always @(posedge clock) begin
        #1;
        rsp_ready = stall_mode ? 1'($urandom_range(0, 1)) : 1'b1;
    end

    task automatic tick();
        @(posedge clock);
        #1;
    endtask

    task automatic reg_access(input irq_pkg::irq_reg_e sel, input logic write,
                              input logic [15:0] wdata);
        logic taken;
        req       = '{sel: sel, write: write, wdata: wdata};
        req_valid = 1'b1;
        taken     = 1'b0;
        while (!taken) begin
            taken = req_ready; // Stable between edges
            tick();
        end
        req_valid = 1'b0;
    endtask

    task automatic pulse_periph(input logic [10:0] bits, input int unsigned settle);
        periph = bits;
        tick();
        periph = '0;
        repeat (settle) tick();
    endtask

    initial begin
        void'($urandom(32'h6efa_c792));
        clock       = 1'b0;
        reset       = 1'b1;
        display_pos = '{hcount: 9'd0, vcount: 8'd0, set_vcount: 8'd200};
        periph      = '0;
        cpu_mode    = mode_user;
        req         = '{sel: irq_pkg::reg_ie, write: 1'b0, wdata: 16'd0};
        req_valid   = 1'b0;
        rsp_ready   = 1'b1;
        stall_mode  = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        // Reset values read back as zero
        reg_access(irq_pkg::reg_ie, 1'b0, 16'd0);
        reg_access(irq_pkg::reg_if, 1'b0, 16'd0);
        reg_access(irq_pkg::reg_ime, 1'b0, 16'd0);

        // Display sweeps, including a held target value
        display_pos.set_vcount = 8'd165;
        for (int x = 230; x <= 250; x++) begin
            display_pos.hcount = 9'(x);
            tick();
        end
        display_pos.hcount = 9'd240;
        repeat (5) tick();
        for (int y = 150; y <= 170; y++) begin
            display_pos.vcount = 8'(y);
            tick();
        end
        display_pos.vcount = 8'd160;
        repeat (5) tick();
        reg_access(irq_pkg::reg_if, 1'b1, 16'h0007);
        repeat (2) tick();

        // IRQ line timing against enable, master enable and CPU mode
        reg_access(irq_pkg::reg_ie, 1'b1, 16'h3fff);
        reg_access(irq_pkg::reg_ime, 1'b1, 16'h0001);
        display_pos.hcount = 9'd0;
        tick();
        display_pos.hcount = 9'd240;
        repeat (4) tick();
        reg_access(irq_pkg::reg_if, 1'b1, 16'h3fff);
        repeat (3) tick();
        pulse_periph(11'b00000000010, 4); // Keypad
        reg_access(irq_pkg::reg_if, 1'b1, 16'h3fff);
        reg_access(irq_pkg::reg_ime, 1'b1, 16'h0000);
        pulse_periph(11'b10000000000, 4); // Timer 3
        reg_access(irq_pkg::reg_if, 1'b1, 16'h3fff);
        reg_access(irq_pkg::reg_ime, 1'b1, 16'h0001);
        reg_access(irq_pkg::reg_ie, 1'b1, 16'h3bff); // DMA 2 masked
        pulse_periph(11'b00000010000, 4);
        reg_access(irq_pkg::reg_ie, 1'b1, 16'h3fff); // Flag was waiting
        repeat (3) tick();
        reg_access(irq_pkg::reg_if, 1'b1, 16'h3fff);
        cpu_mode = irq_pkg::cpsr_mode_irq;
        pulse_periph(11'b00001000000, 4); // Serial
        cpu_mode = mode_user;
        repeat (3) tick();

        // Selective clear and clear racing a new request
        reg_access(irq_pkg::reg_if, 1'b1, 16'h3fff);
        pulse_periph(11'b11110000000, 2); // All timers
        reg_access(irq_pkg::reg_if, 1'b1, 16'h0018);
        reg_access(irq_pkg::reg_if, 1'b1, 16'h0020);
        pulse_periph(11'b01000000000, 2); // Timer 2 again on the ack edge
        reg_access(irq_pkg::reg_if, 1'b0, 16'd0);
        reg_access(irq_pkg::reg_if, 1'b1, 16'h3fff);
        repeat (4) tick();

        // Random traffic with response stalls
        stall_mode = 1'b1;
        for (int i = 0; i < 200; i++) begin
            periph_bits = ($urandom_range(0, 3) == 0) ? 11'($urandom) : 11'd0;
            display_pos.hcount = 9'($urandom_range(238, 242));
            cpu_mode = ($urandom_range(0, 7) == 0) ? irq_pkg::cpsr_mode_irq : mode_user;
            pulse_periph(periph_bits, 0);
            sel_bits = 2'($urandom_range(0, 2));
            reg_access(irq_pkg::irq_reg_e'(sel_bits), 1'($urandom_range(0, 1)),
                       16'($urandom));
        end
        stall_mode = 1'b0;
        while (rsp_valid) tick();
        repeat (4) tick();

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- logic/irq_subsystem.sv
// Top level of the interrupt subsystem, joining event detection, flag capture and register port
`timescale 1ns/1ps

module irq_subsystem (
    input  logic                  clock,
    input  logic                  reset,
    input  irq_pkg::display_pos_t display_pos,
    input  irq_pkg::periph_irq_t  periph,
    input  logic [4:0]            cpu_mode,
    input  irq_pkg::reg_req_t     req,
    input  logic                  req_valid,
    input  logic                  rsp_ready,
    output logic                  nirq,
    output logic                  req_ready,
    output logic [15:0]           rsp_data,
    output logic                  rsp_valid
);

    irq_pkg::irq_mask_t events;  // Display pulses, bits 2:0
    irq_pkg::irq_mask_t ie;
    irq_pkg::irq_mask_t ack;
    irq_pkg::irq_mask_t pending;
    logic               ime;

    display_event_detect display_event_detect_i (
        .clock       (clock),
        .reset       (reset),
        .display_pos (display_pos),
        .events      (events)
    );

    irq_controller irq_controller_i (
        .clock    (clock),
        .reset    (reset),
        .events   (events),
        .periph   (periph),
        .ie       (ie),
        .ime      (ime),
        .ack      (ack),
        .cpu_mode (cpu_mode),
        .pending  (pending),
        .nirq     (nirq)
    );

    irq_reg_port irq_reg_port_i (
        .clock     (clock),
        .reset     (reset),
        .req       (req),
        .req_valid (req_valid),
        .rsp_ready (rsp_ready),
        .pending   (pending),
        .req_ready (req_ready),
        .rsp_data  (rsp_data),
        .rsp_valid (rsp_valid),
        .ie        (ie),
        .ime       (ime),
        .ack       (ack)
    );

endmodule

//--- logic/irq_reg_port.sv
// Valid/ready register port for the enable, flag and master-enable registers
`timescale 1ns/1ps

module irq_reg_port (
    input  logic               clock,
    input  logic               reset,
    input  irq_pkg::reg_req_t  req,
    input  logic               req_valid,
    input  logic               rsp_ready,
    input  irq_pkg::irq_mask_t pending,
    output logic               req_ready,
    output logic [15:0]        rsp_data,
    output logic               rsp_valid,
    output irq_pkg::irq_mask_t ie,
    output logic               ime,
    output irq_pkg::irq_mask_t ack
);

    localparam int unsigned pad_width = 16 - irq_pkg::irq_count;

    logic        accept;
    logic        wr_accept;
    logic [15:0] read_data;

    // One response slot, a new request waits until the slot is empty
    assign req_ready = ~rsp_valid;
    assign accept    = req_valid & req_ready;
    assign wr_accept = accept & req.write;

    always_comb begin
        case (req.sel)
            irq_pkg::reg_ie:  read_data = {{pad_width{1'b0}}, ie};
            irq_pkg::reg_if:  read_data = {{pad_width{1'b0}}, pending}; // Upper bits read zero
            irq_pkg::reg_ime: read_data = {15'd0, ime};
            default:          read_data = 16'd0;
        endcase
    end

    // Register state and the acknowledge pulse
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ie  <= '0;
            ime <= 1'b0;
            ack <= '0;
        end else begin
            ack <= '0; // Pulse lasts one cycle
            if (wr_accept) begin
                case (req.sel)
                    irq_pkg::reg_ie:  ie  <= req.wdata[irq_pkg::irq_count-1:0];
                    irq_pkg::reg_if:  ack <= req.wdata[irq_pkg::irq_count-1:0];
                    irq_pkg::reg_ime: ime <= req.wdata[0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // A write answers with the register contents seen before the write
    always_ff @(posedge clock) begin
        if (accept) begin
            rsp_data <= read_data;
        end
    end

    rsp_data_stable: assert property (
        @(posedge clock) disable iff (reset)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data))
    ) else $error("rsp_data changed while stalled");

    // Transfers are spaced by the response handshake
    ack_one_cycle: assert property (
        @(posedge clock) disable iff (reset)
        (ack != '0) |=> (ack == '0)
    ) else $error("ack high on consecutive cycles");

endmodule

//--- logic/irq_controller.sv
// Sticky interrupt request flags and the registered active-low IRQ line to the CPU
`timescale 1ns/1ps

module irq_controller (
    input  logic                 clock,
    input  logic                 reset,
    input  irq_pkg::irq_mask_t   events,
    input  irq_pkg::periph_irq_t periph,
    input  irq_pkg::irq_mask_t   ie,
    input  logic                 ime,
    input  irq_pkg::irq_mask_t   ack,
    input  logic [4:0]           cpu_mode,
    output irq_pkg::irq_mask_t   pending,
    output logic                 nirq
);

    irq_pkg::irq_mask_t periph_vec; // Peripheral lines in flag order
    irq_pkg::irq_mask_t set_vec;
    irq_pkg::irq_mask_t flags;
    logic               take_irq;

    always_comb begin
        periph_vec = '0;
        periph_vec[irq_pkg::irq_timer0 +: 4] = periph.timer;
        periph_vec[irq_pkg::irq_serial]      = periph.serial;
        periph_vec[irq_pkg::irq_dma0 +: 4]   = periph.dma;
        periph_vec[irq_pkg::irq_keypad]      = periph.keypad;
        periph_vec[irq_pkg::irq_game_pak]    = periph.game_pak;
    end

    assign set_vec = events | periph_vec;

    // Acknowledge takes priority over a request arriving on the same edge
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            flags <= '0;
        end else begin
            flags <= (flags | set_vec) & ~ack;
        end
    end

    assign pending = ie & flags; // Disabled sources are hidden from the CPU

    // No nesting while the CPU already runs its IRQ handler
    assign take_irq = (|pending) & ime & (cpu_mode != irq_pkg::cpsr_mode_irq);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            nirq <= 1'b1;
        end else begin
            nirq <= ~take_irq;
        end
    end

    // A flag written to clear is gone on the next cycle, even if its source fired again
    ack_clears_flag: assert property (
        @(posedge clock) disable iff (reset)
        (ack != '0) |=> ((flags & $past(ack)) == '0)
    ) else $error("acknowledged flag still set");

    // IRQ mode masks the line one edge later
    irq_mode_masks: assert property (
        @(posedge clock) disable iff (reset)
        (cpu_mode == irq_pkg::cpsr_mode_irq) |=> nirq
    ) else $error("nirq asserted while CPU in IRQ mode");

endmodule

//--- logic/display_event_detect.sv
// Edge detector that turns display timing conditions into one-cycle interrupt events
`timescale 1ns/1ps

module display_event_detect (
    input  logic                  clock,
    input  logic                  reset,
    input  irq_pkg::display_pos_t display_pos,
    output irq_pkg::irq_mask_t    events
);

    logic [2:0] cond;      // Hblank, vblank, vcount match
    logic [2:0] cond_prev;

    always_comb begin
        cond[0] = (display_pos.hcount == irq_pkg::hblank_start_x);
        cond[1] = (display_pos.vcount == irq_pkg::vblank_start_line);
        cond[2] = (display_pos.vcount == display_pos.set_vcount);
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cond_prev <= '0;
        end else begin
            cond_prev <= cond;
        end
    end

    // Only the first cycle of each condition raises an event
    always_comb begin
        events = '0; // Peripheral positions stay zero here
        events[irq_pkg::irq_hblank] = cond[0] & ~cond_prev[0];
        events[irq_pkg::irq_vblank] = cond[1] & ~cond_prev[1];
        events[irq_pkg::irq_vcount] = cond[2] & ~cond_prev[2];
    end

    // A held condition must not retrigger on the following cycle
    event_single_cycle: assert property (
        @(posedge clock) disable iff (reset)
        (events != '0) |=> ((events & $past(events)) == '0)
    ) else $error("display event pulse lasted more than one cycle");

endmodule

//--- logic/irq_pkg.sv
// Shared flag layout, display constants and register port types for the interrupt subsystem
package irq_pkg;

    localparam int unsigned irq_count = 14;

    // Display timing targets
    localparam logic [8:0] hblank_start_x    = 9'd240;
    localparam logic [7:0] vblank_start_line = 8'd160;

    localparam logic [4:0] cpsr_mode_irq = 5'b10010; // CPU mode bits while servicing an IRQ

    // Position of each source in the flag, enable and pending words
    typedef enum logic [3:0] {
        irq_hblank   = 4'd0,
        irq_vblank   = 4'd1,
        irq_vcount   = 4'd2,
        irq_timer0   = 4'd3,
        irq_timer1   = 4'd4,
        irq_timer2   = 4'd5,
        irq_timer3   = 4'd6,
        irq_serial   = 4'd7,
        irq_dma0     = 4'd8,
        irq_dma1     = 4'd9,
        irq_dma2     = 4'd10,
        irq_dma3     = 4'd11,
        irq_keypad   = 4'd12,
        irq_game_pak = 4'd13
    } irq_bit_e;

    typedef logic [irq_count-1:0] irq_mask_t;

    typedef struct packed {
        logic [8:0] hcount;     // Dot within the line
        logic [7:0] vcount;     // Current line
        logic [7:0] set_vcount; // Line-compare target
    } display_pos_t;

    // Level-free request pulses from the peripherals
    typedef struct packed {
        logic [3:0] timer;
        logic       serial;
        logic [3:0] dma;
        logic       keypad;
        logic       game_pak;
    } periph_irq_t;

    typedef enum logic [1:0] {
        reg_ie  = 2'd0, // Enable mask
        reg_if  = 2'd1, // Request flags, write one to clear
        reg_ime = 2'd2  // Master enable
    } irq_reg_e;

    typedef struct packed {
        irq_reg_e    sel;
        logic        write;
        logic [15:0] wdata;
    } reg_req_t;

endpackage
